/* build.f */
design/bldc_pkg.sv
design/hall_status_if.sv
design/bridge_drive_if.sv
design/hall_decoder.sv
design/motor_controller.sv
design/bridge_pwm.sv
design/bldc_driver_top.sv
verif/bldc_tb.sv

/* verif/bldc_tb.sv */
// Checks the default parameter set only; the local constants below must match the DUT defaults
`timescale 1ns/100ps

module bldc_tb;

    localparam int PWM_PERIOD      = 64;
    localparam int DUTY_WIDTH      = 7;
    localparam int DEAD_TIME       = 2;
    localparam int MIN_DUTY        = 4;
    localparam int RAMP_STEPS      = 8;
    localparam int RAMP_TICKS      = 64;
    localparam int HALL_SAMPLE_DIV = 4;
    localparam int HALL_STEADY     = 7;
    localparam int SETTLE          = 8;
    localparam int RUN_ROUNDS      = 8;
    // Monitor verdict window, plus the synchronizer and the controller register
    localparam int FAULT_MIN       = HALL_STEADY * HALL_SAMPLE_DIV;
    localparam int FAULT_MAX       = (HALL_STEADY + 1) * HALL_SAMPLE_DIV + 2;
    localparam int RAMP_WINDOWS    = (RAMP_STEPS * RAMP_TICKS + 2 * PWM_PERIOD) / PWM_PERIOD;
    localparam int TIMEOUT_CYCLES  = 6 * (RAMP_STEPS * RAMP_TICKS
                                     + 2 * HALL_STEADY * HALL_SAMPLE_DIV + 4 * PWM_PERIOD);

    // Expected controller state, kept by the test sequence
    typedef enum logic [2:0] {
        M_STOP,
        M_STARTUP,
        M_RUN,
        M_POLL_HALL,
        M_ERR
    } model_state_e;

    logic                  clk;
    logic                  rst_n;
    logic                  en;
    logic [2:0]            hall;
    logic [DUTY_WIDTH-1:0] duty_cycle;
    logic                  direction;
    logic [2:0]            phase_h;
    logic [2:0]            phase_l;
    logic                  connected;
    logic                  fault;

    logic [31:0]  rng;
    model_state_e model;
    int           cycle_count = 0;
    // Last active side per phase (0 none, 1 high, 2 low) and the both-off run since then
    int           last_side [3] = '{0, 0, 0};
    int           off_run   [3] = '{0, 0, 0};
    logic [2:0]   valid_codes [6];

    bldc_driver_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (en),
        .hall       (hall),
        .duty_cycle (duty_cycle),
        .direction  (direction),
        .phase_h    (phase_h),
        .phase_l    (phase_l),
        .connected  (connected),
        .fault      (fault)
    );

    // ==================================================
    // Helpers
    // ==================================================
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act)
            else report_failure($sformatf("CHECK FAILED %s expected %0h got %0h", name, exp, act));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Reference commutation, {source, sink} one-hot with phase A as bit 0
    function automatic logic [5:0] expected_roles(input logic [2:0] code, input logic dir);
        logic [5:0] roles;
        case (code)
            3'b001:  roles = {3'b001, 3'b010};  // A to B
            3'b011:  roles = {3'b001, 3'b100};  // A to C
            3'b010:  roles = {3'b010, 3'b100};  // B to C
            3'b110:  roles = {3'b010, 3'b001};  // B to A
            3'b100:  roles = {3'b100, 3'b001};  // C to A
            3'b101:  roles = {3'b100, 3'b010};  // C to B
            default: roles = 6'b0;
        endcase
        return dir ? {roles[2:0], roles[5:3]} : roles;
    endfunction

    // Picks a valid hall code, a direction and a command above the run threshold
    task automatic pick_inputs(output logic [2:0] code, output logic dir,
                               output logic [DUTY_WIDTH-1:0] cmd);
        rng  = xorshift32(rng);
        code = valid_codes[rng % 6];
        rng  = xorshift32(rng);
        dir  = rng[7];
        rng  = xorshift32(rng);
        cmd  = DUTY_WIDTH'(MIN_DUTY + 1 + rng % (PWM_PERIOD - MIN_DUTY));
    endtask

    // Flags follow the model state, and idle states keep every gate off
    task automatic check_state_outputs();
        check_value("fault", model == M_ERR, fault);
        check_value("connected", model != M_POLL_HALL, connected);
        if (model inside {M_STOP, M_POLL_HALL, M_ERR}) begin
            check_value("phase_h", 3'b000, phase_h);
            check_value("phase_l", 3'b000, phase_l);
        end
    endtask

    task automatic wait_flag(input logic on_fault, input logic level, input int lo, input int hi);
        string name;
        int    n;
        logic  value;
        name = on_fault ? "fault" : "connected";
        n    = 0;
        do begin
            @(negedge clk);
            n++;
            value = on_fault ? fault : connected;
            assert (value === level || n < hi)
                else report_failure($sformatf("%s did not go to %0d within %0d cycles",
                                              name, level, hi));
        end while (value !== level);
        assert (n >= lo)
            else report_failure($sformatf("%s changed after only %0d cycles, expected %0d or more",
                                          name, n, lo));
    endtask

    // High-side on time of the source phase over one PWM period
    task automatic measure_high(input logic [2:0] src, output int count);
        count = 0;
        repeat (PWM_PERIOD) begin
            @(negedge clk);
            if ((phase_h & src) != 3'b000) begin
                count++;
            end
        end
    endtask

    task automatic check_ramp(input logic [DUTY_WIDTH-1:0] cmd, input logic [2:0] src);
        int prev;
        int count;
        prev = 0;
        for (int w = 0; w < RAMP_WINDOWS; w++) begin
            measure_high(src, count);
            assert (count <= cmd)
                else report_failure($sformatf("CHECK FAILED ramp high time expected at most %0h got %0h",
                                              cmd, count));
            assert (count >= prev)
                else report_failure($sformatf("CHECK FAILED ramp high time expected at least %0h got %0h",
                                              prev, count));
            prev = count;
        end
        // The ramp has finished by now and RUN tracks the command
        measure_high(src, count);
        check_value("source high time", cmd, count);
    endtask

    // Sink held low-side on, float fully off, and source on for exactly the duty
    task automatic check_run_window(input logic [2:0] code, input logic dir,
                                    input logic [DUTY_WIDTH-1:0] cmd);
        logic [5:0] roles;
        int         count;
        roles = expected_roles(code, dir);
        count = 0;
        repeat (PWM_PERIOD) begin
            @(negedge clk);
            check_value("phase_l on sink", roles[2:0], phase_l & roles[2:0]);
            check_value("phase_l off sink", 3'b000, phase_l & ~roles[2:0]);
            check_value("phase_h off source", 3'b000, phase_h & ~roles[5:3]);
            if ((phase_h & roles[5:3]) != 3'b000) begin
                count++;
            end
        end
        check_value("source high time", cmd, count);
    endtask

    // ==================================================
    // Clock, timeout and gate monitor
    // ==================================================
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("Timeout after %0d cycles, the test sequence did not finish",
                                     cycle_count));
        end
    end

    // Shoot-through and dead time are watched on every cycle of the run
    always @(negedge clk) begin
        if (rst_n) begin
            for (int p = 0; p < 3; p++) begin
                assert (!(phase_h[p] && phase_l[p]))
                    else report_failure($sformatf("Both gates of phase %0d are on together", p));
                if (phase_h[p] || phase_l[p]) begin
                    // A change of side needs the dead time in between
                    if (last_side[p] != 0 && last_side[p] != (phase_h[p] ? 1 : 2)) begin
                        assert (off_run[p] >= DEAD_TIME)
                            else report_failure($sformatf("Phase %0d switched sides after %0d off cycles",
                                                          p, off_run[p]));
                    end
                    last_side[p] = phase_h[p] ? 1 : 2;
                    off_run[p]   = 0;
                end else begin
                    off_run[p]++;
                end
            end
        end
    end

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin : main_sequence
        logic [2:0]            code;
        logic                  dir;
        logic [DUTY_WIDTH-1:0] cmd;
        logic [5:0]            roles;
        rng         = 32'h376c;
        valid_codes = '{3'b001, 3'b011, 3'b010, 3'b110, 3'b100, 3'b101};
        model       = M_STOP;
        rst_n       = 1'b0;
        en          = 1'b0;
        hall        = 3'b001;
        duty_cycle  = '0;
        direction   = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_state_outputs();

        // Startup ramp from STOP
        pick_inputs(code, dir, cmd);
        @(posedge clk);
        en         <= 1'b1;
        hall       <= code;
        direction  <= dir;
        duty_cycle <= cmd;
        model = M_STARTUP;
        roles = expected_roles(code, dir);
        check_ramp(cmd, roles[5:3]);
        model = M_RUN;

        // Random sectors, directions and commands while running
        for (int i = 0; i < RUN_ROUNDS; i++) begin
            pick_inputs(code, dir, cmd);
            @(posedge clk);
            hall       <= code;
            direction  <= dir;
            duty_cycle <= cmd;
            repeat (SETTLE) @(posedge clk);
            check_run_window(code, dir, cmd);
        end

        // A command at or below the threshold stops the bridge
        rng = xorshift32(rng);
        @(posedge clk);
        duty_cycle <= DUTY_WIDTH'(rng % (MIN_DUTY + 1));
        repeat (SETTLE) @(posedge clk);
        @(negedge clk);
        model = M_STOP;
        check_state_outputs();

        // Unplugged sensor, then reconnect and restart through the ramp
        @(posedge clk);
        hall <= bldc_pkg::HALL_ALL_HIGH;
        wait_flag(1'b0, 1'b0, FAULT_MIN, FAULT_MAX);
        model = M_POLL_HALL;
        check_state_outputs();
        pick_inputs(code, dir, cmd);
        @(posedge clk);
        hall       <= code;
        direction  <= dir;
        duty_cycle <= cmd;
        wait_flag(1'b0, 1'b1, FAULT_MIN, FAULT_MAX);
        model = M_STARTUP;
        roles = expected_roles(code, dir);
        check_ramp(cmd, roles[5:3]);
        model = M_RUN;

        // Hardware fault holds until enable drops
        @(posedge clk);
        hall <= bldc_pkg::HALL_ALL_LOW;
        wait_flag(1'b1, 1'b1, FAULT_MIN, FAULT_MAX);
        model = M_ERR;
        repeat (PWM_PERIOD) begin
            check_state_outputs();
            @(negedge clk);
        end
        @(posedge clk);
        en <= 1'b0;
        @(posedge clk);
        en <= 1'b1;
        model = M_STOP;
        wait_flag(1'b1, 1'b0, 0, 2);
        check_state_outputs();

        // Lines still low, so the fault comes back; all-high then clears it
        wait_flag(1'b1, 1'b1, 0, FAULT_MAX);
        model = M_ERR;
        check_state_outputs();
        @(posedge clk);
        hall <= bldc_pkg::HALL_ALL_HIGH;
        wait_flag(1'b1, 1'b0, 0, SETTLE);
        model = M_POLL_HALL;
        check_state_outputs();
        pick_inputs(code, dir, cmd);
        @(posedge clk);
        hall       <= code;
        direction  <= dir;
        duty_cycle <= cmd;
        wait_flag(1'b0, 1'b1, FAULT_MIN, FAULT_MAX);
        model = M_STARTUP;
        roles = expected_roles(code, dir);
        check_ramp(cmd, roles[5:3]);
        model = M_RUN;

        $display("All tests passed!");
        $finish;
    end

endmodule

/* design/bldc_driver_top.sv */
// All inputs are sampled as levels every cycle; duty_cycle must stay within 0 to PWM_PERIOD
`timescale 1ns/100ps

module bldc_driver_top #(
    parameter int PWM_PERIOD      = 64,
    parameter int DUTY_WIDTH      = 7,
    parameter int DEAD_TIME       = 2,
    parameter int MIN_DUTY        = 4,
    parameter int RAMP_STEPS      = 8,
    parameter int RAMP_TICKS      = 64,
    parameter int HALL_SAMPLE_DIV = 4,
    parameter int HALL_STEADY     = 7
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  en,
    input  logic [2:0]            hall,
    input  logic [DUTY_WIDTH-1:0] duty_cycle,
    input  logic                  direction,
    output logic [2:0]            phase_h,
    output logic [2:0]            phase_l,
    output logic                  connected,
    output logic                  fault
);

    hall_status_if                                 status_bus ();
    bridge_drive_if #(.DUTY_WIDTH(DUTY_WIDTH))     drive_bus  ();

    // Decode stage
    hall_decoder #(
        .HALL_SAMPLE_DIV (HALL_SAMPLE_DIV),
        .HALL_STEADY     (HALL_STEADY)
    ) i_hall_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .direction (direction),
        .hall_raw  (hall),
        .status    (status_bus.decoder)
    );

    // Execute stage
    motor_controller #(
        .DUTY_WIDTH (DUTY_WIDTH),
        .MIN_DUTY   (MIN_DUTY),
        .RAMP_STEPS (RAMP_STEPS),
        .RAMP_TICKS (RAMP_TICKS)
    ) i_motor_controller (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .duty_cmd  (duty_cycle),
        .status    (status_bus.controller),
        .drive     (drive_bus.controller),
        .connected (connected),
        .fault     (fault)
    );

    // Result stage
    bridge_pwm #(
        .PWM_PERIOD (PWM_PERIOD),
        .DUTY_WIDTH (DUTY_WIDTH),
        .DEAD_TIME  (DEAD_TIME)
    ) i_bridge_pwm (
        .clk     (clk),
        .rst_n   (rst_n),
        .drive   (drive_bus.pwm),
        .phase_h (phase_h),
        .phase_l (phase_l)
    );

endmodule

/* design/bridge_pwm.sv */
// Only the source high side is pulsed; the sink low side stays on for the whole sector
`timescale 1ns/100ps

module bridge_pwm #(
    parameter int PWM_PERIOD = 64,
    parameter int DUTY_WIDTH = 7,
    parameter int DEAD_TIME  = 2
) (
    input  logic                            clk,
    input  logic                            rst_n,
    bridge_drive_if.pwm                     drive,
    output logic [bldc_pkg::NUM_PHASES-1:0] phase_h,
    output logic [bldc_pkg::NUM_PHASES-1:0] phase_l
);

    localparam int NP   = bldc_pkg::NUM_PHASES;
    localparam int DT_W = $clog2(DEAD_TIME + 2);
    localparam logic [DUTY_WIDTH-1:0] CNT_LAST = DUTY_WIDTH'(PWM_PERIOD - 1);

    // Per-phase role encoding
    localparam logic [1:0] ROLE_FLOAT = 2'd0;
    localparam logic [1:0] ROLE_SRC   = 2'd1;
    localparam logic [1:0] ROLE_SNK   = 2'd2;

    logic [DUTY_WIDTH-1:0] pwm_cnt;
    logic                  pwm_on;
    logic [1:0]            role_want [NP];
    logic [1:0]            role_q    [NP];
    logic [DT_W-1:0]       dead_cnt  [NP];
    logic                  hold_off  [NP];

    // ==================================================
    // Shared PWM carrier
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pwm_cnt <= '0;
        end else begin
            pwm_cnt <= (pwm_cnt == CNT_LAST) ? '0 : pwm_cnt + 1'b1;
        end
    end

    // A duty equal to the period keeps the high side on the whole time
    assign pwm_on = (pwm_cnt < drive.duty);

    // ==================================================
    // Role tracking and dead time
    // ==================================================
    always_comb begin
        for (int p = 0; p < NP; p++) begin
            if (!drive.enable) begin
                role_want[p] = ROLE_FLOAT;
            end else if (drive.source[p]) begin
                role_want[p] = ROLE_SRC;
            end else if (drive.sink[p]) begin
                role_want[p] = ROLE_SNK;
            end else begin
                role_want[p] = ROLE_FLOAT;
            end
            // Both gates stay off from the change until the dead time has run out
            hold_off[p] = (role_want[p] != role_q[p]) || (dead_cnt[p] != '0);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_h <= '0;
            phase_l <= '0;
            for (int p = 0; p < NP; p++) begin
                role_q[p]   <= ROLE_FLOAT;
                dead_cnt[p] <= '0;
            end
        end else begin
            for (int p = 0; p < NP; p++) begin
                if (role_want[p] != role_q[p]) begin
                    role_q[p]   <= role_want[p];
                    dead_cnt[p] <= DT_W'(DEAD_TIME);
                end else if (dead_cnt[p] != '0) begin
                    dead_cnt[p] <= dead_cnt[p] - 1'b1;
                end
                // A phase holds one role at a time, so its two gates never overlap
                phase_h[p] <= !hold_off[p] && (role_q[p] == ROLE_SRC) && pwm_on;
                phase_l[p] <= !hold_off[p] && (role_q[p] == ROLE_SNK);
            end
        end
    end

endmodule

/* design/motor_controller.sv */
// Assumes RAMP_STEPS is a power of two and duty_cmd never exceeds the PWM period
`timescale 1ns/100ps

module motor_controller #(
    parameter int DUTY_WIDTH = 7,
    parameter int MIN_DUTY   = 4,
    parameter int RAMP_STEPS = 8,
    parameter int RAMP_TICKS = 64
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  en,
    input  logic [DUTY_WIDTH-1:0] duty_cmd,
    hall_status_if.controller     status,
    bridge_drive_if.controller    drive,
    output logic                  connected,
    output logic                  fault
);

    localparam int STEP_SHIFT = $clog2(RAMP_STEPS);
    localparam int TICK_W     = $clog2(RAMP_TICKS + 1);
    localparam int STEPS_W    = $clog2(RAMP_STEPS + 1);
    localparam logic [DUTY_WIDTH-1:0] MIN_D      = DUTY_WIDTH'(MIN_DUTY);
    localparam logic [TICK_W-1:0]     TICK_LAST  = TICK_W'(RAMP_TICKS - 1);
    localparam logic [STEPS_W-1:0]    STEPS_LAST = STEPS_W'(RAMP_STEPS - 1);

    bldc_pkg::motor_state_e          state;
    logic [DUTY_WIDTH-1:0]           duty_q;
    logic [DUTY_WIDTH-1:0]           step_q;
    logic [TICK_W-1:0]               tick_cnt;
    logic [STEPS_W-1:0]              step_cnt;
    logic                            disc_latch;
    logic [bldc_pkg::NUM_PHASES-1:0] src_q;
    logic [bldc_pkg::NUM_PHASES-1:0] snk_q;
    logic                            above_min;
    logic [DUTY_WIDTH-1:0]           ramp_step;
    logic [DUTY_WIDTH:0]             ramp_sum;
    logic [DUTY_WIDTH-1:0]           ramp_next;

    // ==================================================
    // Ramp arithmetic
    // ==================================================
    always_comb begin
        above_min = (duty_cmd > MIN_D);
        // Spread the distance to the command over the ramp, at least one count per step
        ramp_step = (duty_cmd - MIN_D) >> STEP_SHIFT;
        if (ramp_step == '0) begin
            ramp_step = DUTY_WIDTH'(1);
        end
        // One spare bit keeps the sum from wrapping before the clamp
        ramp_sum  = {1'b0, duty_q} + {1'b0, step_q};
        ramp_next = (ramp_sum > {1'b0, duty_cmd}) ? duty_cmd : ramp_sum[DUTY_WIDTH-1:0];
    end

    // ==================================================
    // Control FSM
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= bldc_pkg::STOP;
            duty_q     <= '0;
            step_q     <= '0;
            tick_cnt   <= '0;
            step_cnt   <= '0;
            disc_latch <= 1'b0;
            fault      <= 1'b0;
        end else if (!en) begin
            // Dropping enable clears a hardware fault but remembers a missing sensor
            state  <= bldc_pkg::STOP;
            duty_q <= '0;
            fault  <= 1'b0;
        end else if (status.hw_fault) begin
            state  <= bldc_pkg::ERR;
            duty_q <= '0;
            fault  <= 1'b1;
        end else if (status.open_fault) begin
            state      <= bldc_pkg::POLL_HALL;
            duty_q     <= '0;
            disc_latch <= 1'b1;
        end else begin
            case (state)
                bldc_pkg::STOP: begin
                    tick_cnt <= '0;
                    step_cnt <= '0;
                    if (disc_latch) begin
                        // Re-enabled with the sensor still missing
                        state <= bldc_pkg::POLL_HALL;
                    end else if (above_min) begin
                        duty_q <= MIN_D;
                        step_q <= ramp_step;
                        state  <= bldc_pkg::STARTUP;
                    end else begin
                        duty_q <= '0;
                    end
                end
                bldc_pkg::STARTUP: begin
                    if (!above_min) begin
                        duty_q <= '0;
                        state  <= bldc_pkg::STOP;
                    end else if (tick_cnt == TICK_LAST) begin
                        tick_cnt <= '0;
                        duty_q   <= ramp_next;
                        step_cnt <= step_cnt + 1'b1;
                        // Fixed-length ramp, the step count alone decides when to run
                        if (step_cnt == STEPS_LAST) begin
                            state <= bldc_pkg::RUN;
                        end
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                        // A lowered command pulls the ramp down with it
                        if (duty_q > duty_cmd) begin
                            duty_q <= duty_cmd;
                        end
                    end
                end
                bldc_pkg::RUN: begin
                    if (!above_min) begin
                        duty_q <= '0;
                        state  <= bldc_pkg::STOP;
                    end else begin
                        duty_q <= duty_cmd;
                    end
                end
                bldc_pkg::POLL_HALL: begin
                    if (status.reconnected) begin
                        disc_latch <= 1'b0;
                        state      <= bldc_pkg::STOP;
                    end
                end
                bldc_pkg::ERR: begin
                    // Unplugging the sensor also clears the hardware fault
                    if (status.hall_sync == bldc_pkg::HALL_ALL_HIGH) begin
                        fault      <= 1'b0;
                        disc_latch <= 1'b1;
                        state      <= bldc_pkg::POLL_HALL;
                    end
                end
                default: begin
                    state <= bldc_pkg::STOP;
                end
            endcase
        end
    end

    // Roles are retimed by one cycle to line up with the state register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            src_q <= '0;
            snk_q <= '0;
        end else begin
            src_q <= status.source;
            snk_q <= status.sink;
        end
    end

    assign drive.state    = state;
    assign drive.duty     = duty_q;
    assign drive.source   = drive.enable ? src_q : '0;
    assign drive.sink     = drive.enable ? snk_q : '0;
    assign status.polling = (state == bldc_pkg::POLL_HALL);
    assign connected      = ~disc_latch;

endmodule

/* design/hall_decoder.sv */
// Hall lines are asynchronous and pass a two-flop synchronizer; fault verdicts need HALL_STEADY samples
`timescale 1ns/100ps

module hall_decoder #(
    parameter int HALL_SAMPLE_DIV = 4,
    parameter int HALL_STEADY     = 7
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           direction,
    input  logic [2:0]     hall_raw,
    hall_status_if.decoder status
);

    localparam int DIV_W = $clog2(HALL_SAMPLE_DIV + 1);
    localparam int RUN_W = $clog2(HALL_STEADY + 1);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(HALL_SAMPLE_DIV - 1);
    // A counter holding HALL_STEADY-1 sees its HALL_STEADY-th matching sample next
    localparam logic [RUN_W-1:0] STEADY   = RUN_W'(HALL_STEADY - 1);

    logic [2:0]                        hall_meta;
    logic [2:0]                        hall_q;
    logic [2*bldc_pkg::NUM_PHASES-1:0] roles;
    logic [DIV_W-1:0]                  div_cnt;
    logic                              sample;
    logic [RUN_W-1:0]                  low_cnt;
    logic [RUN_W-1:0]                  high_cnt;
    logic [RUN_W-1:0]                  valid_cnt;

    // ==================================================
    // Synchronizer and commutation decode
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hall_meta <= '0;
            hall_q    <= '0;
        end else begin
            hall_meta <= hall_raw;
            hall_q    <= hall_meta;
        end
    end

    // Role lookup is purely combinational on the synchronized code
    assign roles            = bldc_pkg::commutation_roles(hall_q, direction);
    assign status.hall_sync = hall_q;
    assign status.source    = roles[2*bldc_pkg::NUM_PHASES-1:bldc_pkg::NUM_PHASES];
    assign status.sink      = roles[bldc_pkg::NUM_PHASES-1:0];

    // ==================================================
    // Health monitor
    // ==================================================
    // The monitor only looks at the lines once every HALL_SAMPLE_DIV cycles
    assign sample = (div_cnt == DIV_LAST);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt            <= '0;
            low_cnt            <= '0;
            high_cnt           <= '0;
            valid_cnt          <= '0;
            status.hw_fault    <= 1'b0;
            status.open_fault  <= 1'b0;
            status.reconnected <= 1'b0;
        end else begin
            // Verdicts are single-cycle pulses
            status.hw_fault    <= 1'b0;
            status.open_fault  <= 1'b0;
            status.reconnected <= 1'b0;
            div_cnt            <= sample ? '0 : div_cnt + 1'b1;

            if (sample) begin
                if (hall_q == bldc_pkg::HALL_ALL_LOW) begin
                    // All lines low points at a shorted or dead sensor supply
                    high_cnt  <= '0;
                    valid_cnt <= '0;
                    if (low_cnt == STEADY) begin
                        status.hw_fault <= 1'b1;
                        low_cnt         <= '0;
                    end else begin
                        low_cnt <= low_cnt + 1'b1;
                    end
                end else if (hall_q == bldc_pkg::HALL_ALL_HIGH) begin
                    // All lines pulled high means the connector is off
                    low_cnt   <= '0;
                    valid_cnt <= '0;
                    if (high_cnt == STEADY) begin
                        status.open_fault <= 1'b1;
                        high_cnt          <= '0;
                    end else begin
                        high_cnt <= high_cnt + 1'b1;
                    end
                end else begin
                    low_cnt  <= '0;
                    high_cnt <= '0;
                    // A run of valid codes only counts while a reconnect is awaited
                    if (!status.polling) begin
                        valid_cnt <= '0;
                    end else if (valid_cnt == STEADY) begin
                        status.reconnected <= 1'b1;
                        valid_cnt          <= '0;
                    end else begin
                        valid_cnt <= valid_cnt + 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* design/bridge_drive_if.sv */
// Controller to PWM stage drive request; enable is derived from the carried state
`timescale 1ns/100ps

interface bridge_drive_if #(
    parameter int DUTY_WIDTH = 7
);

    bldc_pkg::motor_state_e          state;
    logic                            enable;
    logic [DUTY_WIDTH-1:0]           duty;
    logic [bldc_pkg::NUM_PHASES-1:0] source;
    logic [bldc_pkg::NUM_PHASES-1:0] sink;

    // The bridge only switches while starting up or running
    assign enable = (state == bldc_pkg::STARTUP) || (state == bldc_pkg::RUN);

    modport controller (
        output state, duty, source, sink,
        input  enable
    );

    modport pwm (
        input enable, duty, source, sink
    );

endinterface

/* design/hall_status_if.sv */
// Decoded hall sector and sensor health pulses; all fields are levels or one-cycle pulses
`timescale 1ns/100ps

interface hall_status_if;

    // Synchronized hall code and the roles looked up from it
    logic [2:0]                      hall_sync;
    logic [bldc_pkg::NUM_PHASES-1:0] source;
    logic [bldc_pkg::NUM_PHASES-1:0] sink;

    // One-cycle monitor verdicts
    logic hw_fault;
    logic open_fault;
    logic reconnected;

    // High while the controller waits for the sensor to come back
    logic polling;

    modport decoder (
        output hall_sync, source, sink, hw_fault, open_fault, reconnected,
        input  polling
    );

    modport controller (
        input  hall_sync, source, sink, hw_fault, open_fault, reconnected,
        output polling
    );

endinterface

/* design/bldc_pkg.sv */
// Shared BLDC types and the commutation table; phase A is bit 0 and direction low runs forward
package bldc_pkg;

    // ==================================================
    // Motor control states
    // ==================================================
    typedef enum logic [2:0] {
        STOP,
        STARTUP,
        RUN,
        POLL_HALL,
        ERR
    } motor_state_e;

    // Pull-ups on the sensor lines make all-high the unplugged pattern
    localparam logic [2:0] HALL_ALL_LOW  = 3'b000;
    localparam logic [2:0] HALL_ALL_HIGH = 3'b111;

    localparam int NUM_PHASES = 3;

    // ==================================================
    // Commutation lookup, returned as {source, sink}
    // ==================================================
    function automatic logic [2*NUM_PHASES-1:0] commutation_roles(
        input logic [2:0] hall,
        input logic       reverse
    );
        logic [2*NUM_PHASES-1:0] fwd;
        // Forward table, source in the upper three bits and sink in the lower three
        case (hall)
            3'b001:  fwd = 6'b001_010;
            3'b011:  fwd = 6'b001_100;
            3'b010:  fwd = 6'b010_100;
            3'b110:  fwd = 6'b010_001;
            3'b100:  fwd = 6'b100_001;
            3'b101:  fwd = 6'b100_010;
            // Fault patterns leave every phase floating
            default: fwd = '0;
        endcase
        // Running in reverse just swaps which phase sources and which sinks
        return reverse ? {fwd[NUM_PHASES-1:0], fwd[2*NUM_PHASES-1:NUM_PHASES]} : fwd;
    endfunction

endpackage
